/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_fetch_mem
FILELIST   := verilog.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
OBJ_DIR    := obj_dir
PASS_MSG   := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* bench/fetch_testdata.txt */
// kind address wdata expected, four words per operation
// kind 0 fetch miss, 1 load, 2 store, 3 fetch hit, 4 load paired with next fetch, ff end
0 100 0 c6ef372fe94f82a0
3 100 0 c6ef372fe94f82a0
// Same index, new tag
0 200 0 8dde6e5fd29f0540
0 100 0 c6ef372fe94f82a0
2 40 1122334455667788 0
1 40 0 1122334455667788
1 10 0 3c6ef372fe94f82a
// Load and fetch miss together
4 20 0 78dde6e5fd29f054
0 400 0 1bbcdcbfa53e0a80
3 400 0 1bbcdcbfa53e0a80
1 8 0 9e3779b97f4a7c15
ff 0 0 0

/* bench/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;   // 10 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

/* bench/tb_fetch_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_mem import mem_pkg::*; ();

  logic              clock;
  logic              reset;
  logic [ADDR_W-1:0] fetch_addr;
  logic [XLEN-1:0]   fetch_data;
  logic              fetch_valid;
  bus_cmd_t          dmem_cmd;
  logic [ADDR_W-1:0] dmem_addr;
  logic [XLEN-1:0]   dmem_wdata;
  logic              dmem_ready;
  logic [XLEN-1:0]   dmem_rdata;
  logic              dmem_done;
  mem_req_t          mem_req;
  mem_rsp_t          mem_rsp;

  logic [63:0] td [0:255];
  logic [64:0] accepted_q [$];   // {is_load, addr} per accepted request
  int          num_ops;
  int          cycles;
  int          cycle_limit;
  int          errors;
  int          tests;
  int          failed_tests;

  tb_clock i_tb_clock (.clock(clock), .reset(reset));

  fetch_mem_top i_fetch_mem_top (
    .clock       (clock),
    .reset       (reset),
    .fetch_addr  (fetch_addr),
    .fetch_data  (fetch_data),
    .fetch_valid (fetch_valid),
    .dmem_cmd    (dmem_cmd),
    .dmem_addr   (dmem_addr),
    .dmem_wdata  (dmem_wdata),
    .dmem_ready  (dmem_ready),
    .dmem_rdata  (dmem_rdata),
    .dmem_done   (dmem_done),
    .mem_req     (mem_req),
    .mem_rsp     (mem_rsp)
  );

  tb_mem_model i_tb_mem_model (
    .clock   (clock),
    .reset   (reset),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  always @(posedge clock) begin
    if (!reset && mem_req.cmd != BUS_NONE && mem_rsp.response != '0)
      accepted_q.push_back({mem_req.cmd == BUS_LOAD, mem_req.addr});
  end

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT never finished a test", cycles);
      $display("Test failed");
      $finish;
    end
  end

  function automatic bit load_seen(int from, logic [63:0] addr);
    for (int i = from; i < accepted_q.size(); i++) begin
      if (accepted_q[i] == {1'b1, addr[63:3], 3'b000}) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic check_value(string what, logic [63:0] got, logic [63:0] exp);
    assert (got === exp) else begin
      $display("ERROR at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(string what, bit ok);
    assert (ok) else begin
      $display("ERROR at %0d ns: %s", $time, what);
      errors++;
    end
  endtask

  task automatic run_fetch(logic [63:0] addr, logic [63:0] exp, bit expect_hit);
    int start;
    start = accepted_q.size();
    @(posedge clock);
    if (expect_hit) begin
      fetch_addr <= addr ^ 64'h8;   // Neighbour word, other index
      @(posedge clock);
    end
    fetch_addr <= addr;
    @(negedge clock);
    if (expect_hit) begin
      check_flag("fetch_valid low on a cached address", fetch_valid);
      check_value("fetch_data", fetch_data, exp);
      @(posedge clock);
      @(negedge clock);
      check_flag("bus load issued on a hit", !load_seen(start, addr));
    end else begin
      while (!fetch_valid) @(negedge clock);
      check_value("fetch_data", fetch_data, exp);
      check_flag("no bus load for a fetch miss", load_seen(start, addr));
    end
  endtask

  task automatic run_data(bus_cmd_t cmd, logic [63:0] addr, logic [63:0] wdata,
                          logic [63:0] exp);
    while (!dmem_ready) @(negedge clock);
    @(posedge clock);
    dmem_cmd   <= cmd;
    dmem_addr  <= addr;
    dmem_wdata <= wdata;
    @(posedge clock);
    dmem_cmd <= BUS_NONE;
    @(negedge clock);
    while (!dmem_done) @(negedge clock);
    if (cmd == BUS_LOAD) check_value("dmem_rdata", dmem_rdata, exp);
  endtask

  // Load and fetch miss start in the same cycle
  task automatic run_pair(logic [63:0] laddr, logic [63:0] lexp,
                          logic [63:0] faddr, logic [63:0] fexp);
    int start;
    bit got_d;
    bit got_f;
    while (!dmem_ready) @(negedge clock);
    start = accepted_q.size();
    got_d = 1'b0;
    got_f = 1'b0;
    @(posedge clock);
    fetch_addr <= faddr;
    dmem_cmd   <= BUS_LOAD;
    dmem_addr  <= laddr;
    @(posedge clock);
    dmem_cmd <= BUS_NONE;
    while (!(got_d && got_f)) begin
      @(negedge clock);
      if (dmem_done) begin
        got_d = 1'b1;
        check_value("dmem_rdata", dmem_rdata, lexp);
      end
      if (fetch_valid && !got_f) begin
        got_f = 1'b1;
        check_value("fetch_data", fetch_data, fexp);
      end
    end
    check_flag("data load was not first on the bus",
               accepted_q.size() > start && accepted_q[start] == {1'b1, laddr});
    check_flag("no bus load for a fetch miss", load_seen(start, faddr));
  endtask

  task automatic report(string name, logic [63:0] addr, int errs_before);
    tests++;
    if (errors != errs_before) failed_tests++;
    $display("test %0d %s %h: %s", tests, name, addr,
             (errors == errs_before) ? "pass" : "FAIL");
  endtask

  initial begin
    int i;
    int errs;
    fetch_addr  = '0;
    dmem_cmd    = BUS_NONE;
    dmem_addr   = '0;
    dmem_wdata  = '0;
    cycles      = 0;
    cycle_limit = 2000;
    errors      = 0;
    tests       = 0;
    failed_tests = 0;
    $readmemh("bench/fetch_testdata.txt", td);
    num_ops = 0;
    while (num_ops < 64 && td[4*num_ops] !== 64'hff) num_ops++;
    cycle_limit = 60 * num_ops + 20;

    @(negedge clock);
    while (reset) @(negedge clock);
    errs = errors;
    check_flag("mem_req busy after reset", mem_req.cmd == BUS_NONE);
    check_flag("fetch_valid high after reset", !fetch_valid);
    check_flag("dmem_done high after reset", !dmem_done);
    check_flag("dmem_ready low after reset", dmem_ready);
    report("reset", '0, errs);

    i = 0;
    while (i < num_ops) begin
      errs = errors;
      case (td[4*i])
        64'h0: run_fetch(td[4*i+1], td[4*i+3], 1'b0);
        64'h3: run_fetch(td[4*i+1], td[4*i+3], 1'b1);
        64'h1: run_data(BUS_LOAD, td[4*i+1], td[4*i+2], td[4*i+3]);
        64'h2: run_data(BUS_STORE, td[4*i+1], td[4*i+2], td[4*i+3]);
        64'h4: begin
          run_pair(td[4*i+1], td[4*i+3], td[4*i+5], td[4*i+7]);
          i++;
        end
        default: check_flag("unknown operation in the data file", 1'b0);
      endcase
      report((td[4*i] == 64'h0 || td[4*i] == 64'h3) ? "fetch" : "data", td[4*i+1], errs);
      i++;
    end

    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/tb_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model import mem_pkg::*; (
  input  wire logic     clock,
  input  wire logic     reset,
  input  wire mem_req_t mem_req,
  output mem_rsp_t      mem_rsp
);

  typedef struct packed {
    logic [TAG_ID_W-1:0] tag;
    logic [XLEN-1:0]     data;
    logic [31:0]         due;
  } pend_t;

  pend_t               pending [$];
  logic [XLEN-1:0]     store_tbl [logic [60:0]];   // Written words only
  logic [TAG_ID_W-1:0] next_tag;
  logic [TAG_ID_W-1:0] reply_tag;
  logic [XLEN-1:0]     reply_data;
  int                  cycle;
  int                  seed = 32'h25b9;

  function automatic logic [XLEN-1:0] rule_value(logic [60:0] word);
    return {3'b000, word} * 64'h9e3779b97f4a7c15;
  endfunction

  // Every request is taken at once
  always_comb begin
    mem_rsp.response = (mem_req.cmd != BUS_NONE) ? next_tag : '0;
    mem_rsp.data     = reply_data;
    mem_rsp.tag      = reply_tag;
  end

  always @(posedge clock) begin : step
    pend_t      entry;
    int         lat;
    int         idx;
    logic [60:0] word;
    if (reset) begin
      next_tag   <= 4'd1;
      reply_tag  <= '0;
      reply_data <= '0;
      pending.delete();
      cycle = 0;
    end else begin
      cycle = cycle + 1;
      if (mem_req.cmd != BUS_NONE) begin
        lat       = 1 + int'($unsigned($random(seed)) % 6);
        word      = mem_req.addr[63:3];
        entry.tag = next_tag;
        entry.due = cycle + lat;
        if (mem_req.cmd == BUS_STORE) begin
          store_tbl[word] = mem_req.data;
          entry.data = '0;
        end else begin
          entry.data = store_tbl.exists(word) ? store_tbl[word] : rule_value(word);
        end
        pending.push_back(entry);
        next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
      end
      idx = -1;
      for (int i = 0; i < pending.size(); i++) begin
        if (idx < 0 && pending[i].due <= cycle) idx = i;
      end
      reply_tag <= '0;
      if (idx >= 0) begin
        reply_tag  <= pending[idx].tag;
        reply_data <= pending[idx].data;
        pending.delete(idx);
      end
    end
  end

endmodule

`default_nettype wire

/* hw/dmem_port.sv */
`timescale 1ns/1ps
`default_nettype none

module dmem_port import mem_pkg::*; (
  input  wire logic              clock,
  input  wire logic              reset,
  input  wire bus_cmd_t          dmem_cmd,
  input  wire logic [ADDR_W-1:0] dmem_addr,
  input  wire logic [XLEN-1:0]   dmem_wdata,
  output logic                   dmem_ready,
  output logic      [XLEN-1:0]   dmem_rdata,
  output logic                   dmem_done,
  output mem_req_t               dmem_req,
  input  wire mem_rsp_t          dmem_rsp
);

  typedef enum logic [1:0] {
    DP_IDLE,
    DP_REQ,
    DP_WAIT     // Load accepted, reply pending
  } dp_state_t;

  dp_state_t           state;
  mem_req_t            held_req;
  logic [TAG_ID_W-1:0] load_tag;
  logic                accepted;
  logic                store_done;
  logic                load_done;

  assign accepted   = (state == DP_REQ) && (dmem_rsp.response != '0);
  assign store_done = accepted && (held_req.cmd == BUS_STORE);
  assign load_done  = (state == DP_WAIT) && (dmem_rsp.tag != '0) &&
                      (dmem_rsp.tag == load_tag);

  assign dmem_ready = (state == DP_IDLE);
  assign dmem_done  = store_done || load_done;
  assign dmem_rdata = dmem_rsp.data;

  // Held stable on the bus until a tag comes back
  always_comb begin
    dmem_req = held_req;
    if (state != DP_REQ) begin
      dmem_req.cmd = BUS_NONE;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= DP_IDLE;
    end else begin
      case (state)
        DP_IDLE: if (dmem_cmd != BUS_NONE) state <= DP_REQ;
        DP_REQ: begin
          if (accepted) state <= store_done ? DP_IDLE : DP_WAIT;
        end
        DP_WAIT: if (load_done) state <= DP_IDLE;
        default: state <= DP_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == DP_IDLE && dmem_cmd != BUS_NONE) begin
      held_req <= '{cmd: dmem_cmd, addr: dmem_addr, data: dmem_wdata};
    end
    if (accepted) begin
      load_tag <= dmem_rsp.response;
    end
  end

  // A tag is only handed out for a request this port has on the bus
  a_rsp_when_req: assert property (@(posedge clock) disable iff (reset)
    dmem_rsp.response != '0 |-> state == DP_REQ);

endmodule

`default_nettype wire

/* hw/fetch_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_mem_top import mem_pkg::*; (
  input  wire logic              clock,
  input  wire logic              reset,
  input  wire logic [ADDR_W-1:0] fetch_addr,
  output logic      [XLEN-1:0]   fetch_data,
  output logic                   fetch_valid,
  input  wire bus_cmd_t          dmem_cmd,
  input  wire logic [ADDR_W-1:0] dmem_addr,
  input  wire logic [XLEN-1:0]   dmem_wdata,
  output logic                   dmem_ready,
  output logic      [XLEN-1:0]   dmem_rdata,
  output logic                   dmem_done,
  output mem_req_t               mem_req,
  input  wire mem_rsp_t          mem_rsp
);

  mem_req_t         imem_req;
  mem_req_t         dmem_req;
  mem_rsp_t         imem_rsp;
  mem_rsp_t         dmem_rsp;
  logic [IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0] rd_tag;
  logic [XLEN-1:0]  rd_data;
  logic             rd_valid;
  logic             wr_en;
  logic [IDX_W-1:0] wr_idx;
  logic [TAG_W-1:0] wr_tag;

  icache_mem i_icache_mem (
    .clock    (clock),
    .reset    (reset),
    .wr_en    (wr_en),
    .wr_idx   (wr_idx),
    .wr_tag   (wr_tag),
    .wr_data  (imem_rsp.data),   // Refill straight from the reply
    .rd_idx   (rd_idx),
    .rd_tag   (rd_tag),
    .rd_data  (rd_data),
    .rd_valid (rd_valid)
  );

  icache_ctrl i_icache_ctrl (
    .clock       (clock),
    .reset       (reset),
    .fetch_addr  (fetch_addr),
    .fetch_data  (fetch_data),
    .fetch_valid (fetch_valid),
    .rd_idx      (rd_idx),
    .rd_tag      (rd_tag),
    .rd_data     (rd_data),
    .rd_valid    (rd_valid),
    .wr_en       (wr_en),
    .wr_idx      (wr_idx),
    .wr_tag      (wr_tag),
    .imem_req    (imem_req),
    .imem_rsp    (imem_rsp)
  );

  dmem_port i_dmem_port (
    .clock      (clock),
    .reset      (reset),
    .dmem_cmd   (dmem_cmd),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_ready (dmem_ready),
    .dmem_rdata (dmem_rdata),
    .dmem_done  (dmem_done),
    .dmem_req   (dmem_req),
    .dmem_rsp   (dmem_rsp)
  );

  mem_bus_arbiter i_mem_bus_arbiter (
    .clock    (clock),
    .reset    (reset),
    .imem_req (imem_req),
    .dmem_req (dmem_req),
    .imem_rsp (imem_rsp),
    .dmem_rsp (dmem_rsp),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp)
  );

endmodule

`default_nettype wire

/* hw/icache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl import mem_pkg::*; (
  input  wire logic              clock,
  input  wire logic              reset,
  input  wire logic [ADDR_W-1:0] fetch_addr,
  output logic      [XLEN-1:0]   fetch_data,
  output logic                   fetch_valid,
  output logic      [IDX_W-1:0]  rd_idx,
  output logic      [TAG_W-1:0]  rd_tag,
  input  wire logic [XLEN-1:0]   rd_data,
  input  wire logic              rd_valid,
  output logic                   wr_en,
  output logic      [IDX_W-1:0]  wr_idx,
  output logic      [TAG_W-1:0]  wr_tag,
  output mem_req_t               imem_req,
  input  wire mem_rsp_t          imem_rsp
);

  typedef enum logic [1:0] {
    IC_IDLE,
    IC_REQ,     // Load on the bus, waiting for a tag
    IC_WAIT     // Tag held, waiting for the reply
  } ic_state_t;

  ic_state_t           state;
  logic [ADDR_W-1:0]   miss_addr;
  logic [TAG_ID_W-1:0] miss_mem_tag;
  logic                reply_hit;

  assign rd_idx      = fetch_addr[OFFSET_W +: IDX_W];
  assign rd_tag      = fetch_addr[OFFSET_W+IDX_W +: TAG_W];
  assign fetch_data  = rd_data;
  assign fetch_valid = rd_valid;   // Hit in the same cycle

  assign reply_hit = (state == IC_WAIT) && (imem_rsp.tag != '0) &&
                     (imem_rsp.tag == miss_mem_tag);

  // Refill goes to the line that missed, wherever fetch_addr is now
  assign wr_en  = reply_hit;
  assign wr_idx = miss_addr[OFFSET_W +: IDX_W];
  assign wr_tag = miss_addr[OFFSET_W+IDX_W +: TAG_W];

  always_comb begin
    imem_req      = '0;
    imem_req.cmd  = BUS_NONE;
    if (state == IC_REQ) begin
      imem_req.cmd  = BUS_LOAD;
      imem_req.addr = miss_addr;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IC_IDLE;
    end else begin
      case (state)
        IC_IDLE: if (!rd_valid) state <= IC_REQ;
        IC_REQ:  if (imem_rsp.response != '0) state <= IC_WAIT;
        IC_WAIT: if (reply_hit) state <= IC_IDLE;
        default: state <= IC_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == IC_IDLE && !rd_valid) begin
      miss_addr <= {fetch_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    end
    if (state == IC_REQ && imem_rsp.response != '0) begin
      miss_mem_tag <= imem_rsp.response;
    end
  end

  // Any reply routed here must be the single outstanding miss
  a_single_tag: assert property (@(posedge clock) disable iff (reset)
    imem_rsp.tag != '0 |-> state == IC_WAIT && imem_rsp.tag == miss_mem_tag);

endmodule

`default_nettype wire

/* hw/icache_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_mem import mem_pkg::*; (
  input  wire logic             clock,
  input  wire logic             reset,
  input  wire logic             wr_en,
  input  wire logic [IDX_W-1:0] wr_idx,
  input  wire logic [TAG_W-1:0] wr_tag,
  input  wire logic [XLEN-1:0]  wr_data,
  input  wire logic [IDX_W-1:0] rd_idx,
  input  wire logic [TAG_W-1:0] rd_tag,
  output logic      [XLEN-1:0]  rd_data,
  output logic                  rd_valid
);

  logic [XLEN-1:0]      data_mem [NUM_LINES];
  logic [TAG_W-1:0]     tag_mem  [NUM_LINES];
  logic [NUM_LINES-1:0] valid_mem;

  // Combinational lookup
  assign rd_data  = data_mem[rd_idx];
  assign rd_valid = valid_mem[rd_idx] && (tag_mem[rd_idx] == rd_tag);

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_mem <= '0;
    end else if (wr_en) begin
      valid_mem[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      data_mem[wr_idx] <= wr_data;
      tag_mem[wr_idx]  <= wr_tag;   // Evicts whatever was there
    end
  end

endmodule

`default_nettype wire

/* hw/mem_bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_bus_arbiter import mem_pkg::*; (
  input  wire logic     clock,
  input  wire logic     reset,
  input  wire mem_req_t imem_req,
  input  wire mem_req_t dmem_req,
  output mem_rsp_t      imem_rsp,
  output mem_rsp_t      dmem_rsp,
  output mem_req_t      mem_req,
  input  wire mem_rsp_t mem_rsp
);

  logic [NUM_TAGS-1:0] owned;
  logic [NUM_TAGS-1:0] owner_d;    // Set when the data side owns the tag
  logic                dmem_grant;
  logic                accept;
  logic                reply;
  logic                reply_to_d;

  // Data side wins whenever it asks
  assign dmem_grant = (dmem_req.cmd != BUS_NONE);
  assign mem_req    = dmem_grant ? dmem_req : imem_req;

  assign accept     = (mem_req.cmd != BUS_NONE) && (mem_rsp.response != '0);
  assign reply      = (mem_rsp.tag != '0) && owned[mem_rsp.tag];
  assign reply_to_d = reply && owner_d[mem_rsp.tag];

  always_comb begin
    imem_rsp = mem_rsp;
    dmem_rsp = mem_rsp;
    imem_rsp.response = dmem_grant ? '0 : mem_rsp.response;
    dmem_rsp.response = dmem_grant ? mem_rsp.response : '0;
    imem_rsp.tag      = (reply && !reply_to_d) ? mem_rsp.tag : '0;
    dmem_rsp.tag      = reply_to_d ? mem_rsp.tag : '0;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      owned <= '0;
    end else begin
      if (reply) owned[mem_rsp.tag] <= 1'b0;
      if (accept) owned[mem_rsp.response] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) owner_d[mem_rsp.response] <= dmem_grant;
  end

  // Memory only replies to tags it handed out earlier
  a_reply_owned: assert property (@(posedge clock) disable iff (reset)
    mem_rsp.tag != '0 |-> owned[mem_rsp.tag]);

endmodule

`default_nettype wire

/* hw/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  localparam int XLEN      = 64;
  localparam int ADDR_W    = 64;

  // Address split for the instruction cache
  localparam int OFFSET_W  = 3;
  localparam int IDX_W     = 5;
  localparam int TAG_W     = 8;    // Bits above 16 ignored
  localparam int NUM_LINES = 32;

  // Memory transaction tags, 0 means no tag
  localparam int TAG_ID_W  = 4;
  localparam int NUM_TAGS  = 16;

  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_cmd_t;

  typedef struct packed {
    bus_cmd_t            cmd;
    logic [ADDR_W-1:0]   addr;
    logic [XLEN-1:0]     data;    // Store data
  } mem_req_t;

  typedef struct packed {
    logic [TAG_ID_W-1:0] response;  // Nonzero when the request is taken
    logic [XLEN-1:0]     data;
    logic [TAG_ID_W-1:0] tag;       // Tag of the reply in data
  } mem_rsp_t;

endpackage

`default_nettype wire

/* verilog.f */
hw/mem_pkg.sv
hw/icache_mem.sv
hw/icache_ctrl.sv
hw/dmem_port.sv
hw/mem_bus_arbiter.sv
hw/fetch_mem_top.sv
bench/tb_clock.sv
bench/tb_mem_model.sv
bench/tb_fetch_mem.sv
